// File: all.f
logic/flip_pick_pkg.sv
logic/break_value_counter.sv
logic/heuristic_selector.sv
logic/break_counter_selector.sv
logic/wb_flip_regs.sv
logic/flip_picker_top.sv
test/tb_flip_picker.sv

// File: logic/break_counter_selector.sv
/*
 break counter selector
 one break value counter per candidate row feeding the heuristic selector;
 the chosen row and its count are registered on a start pulse
*/
module break_counter_selector (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  flip_pick_pkg::clause_row_t rows_i [flip_pick_pkg::NUM_ROWS],
    input  logic                       noise_en_i,
    input  flip_pick_pkg::row_idx_t    rand_row_i,
    input  logic                       start_i,
    output flip_pick_pkg::pick_result_t result_o,
    output logic                       done_o
);
    import flip_pick_pkg::*;

    // per-row counts and masked vectors
    break_val_t  break_values [NUM_ROWS];
    clause_vec_t clause_vecs  [NUM_ROWS];

    // combinational choice for this cycle
    row_idx_t    sel_row;
    logic        sel_zero;

    // set by a capture, held until the next start
    logic        done_q;

    // one counter per candidate row
    genvar r;
    generate
        for (r = 0; r < NUM_ROWS; r++) begin : g_row
            break_value_counter u_counter (
                .row_i           (rows_i[r]),
                .break_value_o   (break_values[r]),
                .clause_broken_o (clause_vecs[r])
            );
        end
    endgenerate

    heuristic_selector u_selector (
        .break_values_i (break_values),
        .noise_en_i     (noise_en_i),
        .rand_row_i     (rand_row_i),
        .row_o          (sel_row),
        .zero_break_o   (sel_zero)
    );

    // capture at the end of the start cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            result_o <= '0;
            done_q   <= 1'b0;
        end else if (start_i) begin
            // selector never hands out an index past the last row
            result_o.row           <= sel_row;
            result_o.break_value   <= break_values[sel_row];
            result_o.zero_break    <= sel_zero;
            result_o.clause_broken <= clause_vecs[sel_row];
            done_q                 <= 1'b1;
        end
    end

    // a new start hides the old done right away
    assign done_o = done_q & ~start_i;

endmodule

// File: logic/break_value_counter.sv
/*
 break value counter
 counts the clauses a flip of this row's variable would break, limited to
 clauses the row really contains, and forwards the masked clause vector
*/
module break_value_counter (
    input  flip_pick_pkg::clause_row_t row_i,
    output flip_pick_pkg::break_val_t  break_value_o,
    output flip_pick_pkg::clause_vec_t clause_broken_o
);
    import flip_pick_pkg::*;

    // levels needed to reduce NUM_CLAUSES leaves to one sum
    localparam int TREE_LEVELS = $clog2(NUM_CLAUSES);

    // broken clauses that belong to this row
    clause_vec_t masked;

    // partial sums, one row of nodes per tree level
    break_val_t node_sum [TREE_LEVELS+1][NUM_CLAUSES];

    assign masked          = row_i.broken & row_i.mask;
    assign clause_broken_o = masked;

    genvar lvl, n;
    generate
        // leaves are the masked bits widened to a count
        for (n = 0; n < NUM_CLAUSES; n++) begin : g_leaf
            assign node_sum[0][n] = break_val_t'(masked[n]);
        end

        for (lvl = 0; lvl < TREE_LEVELS; lvl++) begin : g_level
            // nodes present at this level and the one above
            localparam int CUR_NODES = (NUM_CLAUSES + (1 << lvl) - 1) >> lvl;
            localparam int NXT_NODES = (CUR_NODES + 1) / 2;

            for (n = 0; n < NUM_CLAUSES; n++) begin : g_node
                if (2 * n + 1 < CUR_NODES) begin : g_pair
                    // pairwise add of neighbours
                    assign node_sum[lvl+1][n] = node_sum[lvl][2*n] + node_sum[lvl][2*n+1];
                end else if (n < NXT_NODES) begin : g_odd
                    // odd node has no partner, passes up as is
                    assign node_sum[lvl+1][n] = node_sum[lvl][2*n];
                end else begin : g_unused
                    // slot beyond this level's width
                    assign node_sum[lvl+1][n] = '0;
                end
            end
        end
    endgenerate

    // root of the tree
    assign break_value_o = node_sum[TREE_LEVELS][0];

endmodule

// File: logic/flip_pick_pkg.sv
/*
 flip pick package
 sizes, vector and struct types, Wishbone bus types and register map
 shared by the break-value counting and flip selection logic
*/
package flip_pick_pkg;

    // clauses per clause table row
    localparam int NUM_CLAUSES      = 20;
    // candidate variables evaluated together
    localparam int NUM_ROWS         = 3;
    // wide enough for a count of up to NUM_CLAUSES
    localparam int NUM_CLAUSES_BITS = 5;
    localparam int ROW_BITS         = 2;

    localparam int WB_DATA_BITS     = 32;
    localparam int WB_ADDR_BITS     = 4;

    typedef logic [NUM_CLAUSES-1:0]      clause_vec_t;
    typedef logic [NUM_CLAUSES_BITS-1:0] break_val_t;
    typedef logic [ROW_BITS-1:0]         row_idx_t;

    // one candidate row as written by the host
    typedef struct packed {
        clause_vec_t broken;
        clause_vec_t mask;
    } clause_row_t;

    // registered outcome of one pick
    typedef struct packed {
        row_idx_t    row;
        break_val_t  break_value;
        logic        zero_break;
        clause_vec_t clause_broken;
    } pick_result_t;

    // master side of a Wishbone classic cycle
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [WB_ADDR_BITS-1:0] adr;
        logic [WB_DATA_BITS-1:0] dat;
    } wb_req_t;

    // slave side
    typedef struct packed {
        logic                    ack;
        logic [WB_DATA_BITS-1:0] dat;
    } wb_rsp_t;

    // word addresses
    localparam logic [WB_ADDR_BITS-1:0] REG_BROKEN0    = 4'd0;
    localparam logic [WB_ADDR_BITS-1:0] REG_BROKEN1    = 4'd1;
    localparam logic [WB_ADDR_BITS-1:0] REG_BROKEN2    = 4'd2;
    localparam logic [WB_ADDR_BITS-1:0] REG_MASK0      = 4'd4;
    localparam logic [WB_ADDR_BITS-1:0] REG_MASK1      = 4'd5;
    localparam logic [WB_ADDR_BITS-1:0] REG_MASK2      = 4'd6;
    localparam logic [WB_ADDR_BITS-1:0] REG_CTRL       = 4'd8;
    localparam logic [WB_ADDR_BITS-1:0] REG_START      = 4'd9;
    localparam logic [WB_ADDR_BITS-1:0] REG_STATUS     = 4'd12;
    localparam logic [WB_ADDR_BITS-1:0] REG_RESULT     = 4'd13;
    localparam logic [WB_ADDR_BITS-1:0] REG_RESULT_VEC = 4'd14;

endpackage

// File: logic/flip_picker_top.sv
/*
 flip picker top
 Wishbone register slave in front of the break counter and flip selector
*/
module flip_picker_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  flip_pick_pkg::wb_req_t wb_req_i,
    output flip_pick_pkg::wb_rsp_t wb_rsp_o
);
    import flip_pick_pkg::*;

    // operands from the register slave
    clause_row_t  rows [NUM_ROWS];
    logic         noise_en;
    row_idx_t     rand_row;
    logic         start;

    // result back to the register slave
    pick_result_t result;
    logic         done;

    wb_flip_regs u_regs (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .result_i   (result),
        .done_i     (done),
        .rows_o     (rows),
        .noise_en_o (noise_en),
        .rand_row_o (rand_row),
        .start_o    (start)
    );

    break_counter_selector u_pick (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rows_i     (rows),
        .noise_en_i (noise_en),
        .rand_row_i (rand_row),
        .start_i    (start),
        .result_o   (result),
        .done_o     (done)
    );

endmodule

// File: logic/heuristic_selector.sv
/*
 heuristic selector
 picks the row to flip: a zero-break row first, else the host's random
 row when noise is on, else the lowest-index row with the smallest count
*/
module heuristic_selector (
    input  flip_pick_pkg::break_val_t break_values_i [flip_pick_pkg::NUM_ROWS],
    input  logic                      noise_en_i,
    input  flip_pick_pkg::row_idx_t   rand_row_i,
    output flip_pick_pkg::row_idx_t   row_o,
    output logic                      zero_break_o
);
    import flip_pick_pkg::*;

    // freebie search result
    logic       zero_found;
    row_idx_t   zero_row;

    // greedy search result
    row_idx_t   min_row;
    break_val_t min_val;

    // random row folded into range
    row_idx_t   noise_row;

    // lowest row with break value zero
    always_comb begin
        zero_found = 1'b0;
        zero_row   = '0;
        // walk downwards so the lowest index is the last one kept
        for (int r = NUM_ROWS - 1; r >= 0; r--) begin
            if (break_values_i[r] == '0) begin
                zero_found = 1'b1;
                zero_row   = row_idx_t'(r);
            end
        end
    end

    // lowest row holding the minimum
    always_comb begin
        min_row = '0;
        min_val = break_values_i[0];
        for (int r = 1; r < NUM_ROWS; r++) begin
            // strict compare keeps the earlier row on a tie
            if (break_values_i[r] < min_val) begin
                min_row = row_idx_t'(r);
                min_val = break_values_i[r];
            end
        end
    end

    // indices past the last row wrap back, so 3 maps to 0
    always_comb begin
        if (rand_row_i >= row_idx_t'(NUM_ROWS)) begin
            noise_row = rand_row_i - row_idx_t'(NUM_ROWS);
        end else begin
            noise_row = rand_row_i;
        end
    end

    // priority: freebie, then noise, then greedy
    always_comb begin
        if (zero_found) begin
            row_o = zero_row;
        end else if (noise_en_i) begin
            row_o = noise_row;
        end else begin
            row_o = min_row;
        end
    end

    assign zero_break_o = zero_found;

endmodule

// File: logic/wb_flip_regs.sv
/*
 flip register slave
 Wishbone classic slave with one wait state; holds the candidate rows,
 noise control and start pulse, and reads back status and the last result
*/
module wb_flip_regs (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  flip_pick_pkg::wb_req_t      wb_req_i,
    output flip_pick_pkg::wb_rsp_t      wb_rsp_o,
    input  flip_pick_pkg::pick_result_t result_i,
    input  logic                        done_i,
    output flip_pick_pkg::clause_row_t  rows_o [flip_pick_pkg::NUM_ROWS],
    output logic                        noise_en_o,
    output flip_pick_pkg::row_idx_t     rand_row_o,
    output logic                        start_o
);
    import flip_pick_pkg::*;

    // bus request qualifiers
    logic                    req_active;
    logic                    req_new;
    logic                    wr_en;

    logic                    ack_q;
    logic [WB_DATA_BITS-1:0] rd_data;
    logic [WB_DATA_BITS-1:0] rd_data_q;

    // operand and control state
    clause_row_t             rows_q [NUM_ROWS];
    logic                    noise_en_q;
    row_idx_t                rand_row_q;
    logic                    start_q;

    assign req_active = wb_req_i.cyc & wb_req_i.stb;
    // request not already being acknowledged
    assign req_new    = req_active & ~ack_q;
    // writes land in the ack cycle
    assign wr_en      = req_active & ack_q & wb_req_i.we;

    // ack one cycle after the request shows up, for one cycle only
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_new;
        end
    end

    // operand, control and start registers
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                rows_q[r] <= '0;
            end
            noise_en_q <= 1'b0;
            rand_row_q <= '0;
            start_q    <= 1'b0;
        end else begin
            // start is a pulse, low unless written this cycle
            start_q <= wr_en && (wb_req_i.adr == REG_START) && wb_req_i.dat[0];
            if (wr_en) begin
                case (wb_req_i.adr)
                    REG_BROKEN0: rows_q[0].broken <= wb_req_i.dat[NUM_CLAUSES-1:0];
                    REG_BROKEN1: rows_q[1].broken <= wb_req_i.dat[NUM_CLAUSES-1:0];
                    REG_BROKEN2: rows_q[2].broken <= wb_req_i.dat[NUM_CLAUSES-1:0];
                    REG_MASK0:   rows_q[0].mask   <= wb_req_i.dat[NUM_CLAUSES-1:0];
                    REG_MASK1:   rows_q[1].mask   <= wb_req_i.dat[NUM_CLAUSES-1:0];
                    REG_MASK2:   rows_q[2].mask   <= wb_req_i.dat[NUM_CLAUSES-1:0];
                    REG_CTRL: begin
                        noise_en_q <= wb_req_i.dat[0];
                        rand_row_q <= wb_req_i.dat[ROW_BITS:1];
                    end
                    // read-only and unused addresses take no data
                    default: ;
                endcase
            end
        end
    end

    // read mux, unused fields stay zero
    always_comb begin
        rd_data = '0;
        case (wb_req_i.adr)
            REG_BROKEN0:    rd_data[NUM_CLAUSES-1:0] = rows_q[0].broken;
            REG_BROKEN1:    rd_data[NUM_CLAUSES-1:0] = rows_q[1].broken;
            REG_BROKEN2:    rd_data[NUM_CLAUSES-1:0] = rows_q[2].broken;
            REG_MASK0:      rd_data[NUM_CLAUSES-1:0] = rows_q[0].mask;
            REG_MASK1:      rd_data[NUM_CLAUSES-1:0] = rows_q[1].mask;
            REG_MASK2:      rd_data[NUM_CLAUSES-1:0] = rows_q[2].mask;
            REG_CTRL:       rd_data[ROW_BITS:0]      = {rand_row_q, noise_en_q};
            REG_STATUS:     rd_data[0]               = done_i;
            // row in the low bits, then count, then zero flag
            REG_RESULT: begin
                rd_data[ROW_BITS+NUM_CLAUSES_BITS:0] = {result_i.zero_break,
                                                        result_i.break_value,
                                                        result_i.row};
            end
            REG_RESULT_VEC: rd_data[NUM_CLAUSES-1:0] = result_i.clause_broken;
            default:        rd_data = '0;
        endcase
    end

    // read data sampled together with the ack
    always_ff @(posedge clk) begin
        if (req_new) begin
            rd_data_q <= rd_data;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rd_data_q;

    assign rows_o     = rows_q;
    assign noise_en_o = noise_en_q;
    assign rand_row_o = rand_row_q;
    assign start_o    = start_q;

endmodule

// File: run.sh
#!/bin/sh
# build the flip picker testbench with Verilator and run it
# the script exits with the simulator's status, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_flip_picker \
    -f all.f --Mdir obj_dir -o sim_flip_picker
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_flip_picker
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
fi
exit "$status"

// File: test/tb_flip_picker.sv
/*
 flip picker testbench
 drives the Wishbone slave through a table of picks and a random phase,
 checking each registered result against the selection rules
*/
module tb_flip_picker;
    import flip_pick_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int ACK_TIMEOUT  = 8;
    localparam int DONE_TIMEOUT = 16;
    localparam int NUM_CASES    = 10;
    localparam int NUM_RANDOM   = 40;

    typedef logic [WB_ADDR_BITS-1:0] wb_adr_t;
    typedef logic [WB_DATA_BITS-1:0] wb_dat_t;

    // operands of one pick and the result it should give
    typedef struct packed {
        clause_vec_t [NUM_ROWS-1:0] broken;
        clause_vec_t [NUM_ROWS-1:0] mask;
        logic                       noise_en;
        row_idx_t                   rand_row;
        pick_result_t               expected;
    } case_t;

    logic        clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    case_t       cases [NUM_CASES];
    logic [31:0] rng_state;

    flip_picker_top u_dut (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_row(input string name, input row_idx_t exp, input row_idx_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s expected %0d actual %0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_break(input string name, input break_val_t exp, input break_val_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s expected %0d actual %0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    task automatic check_vec(input string name, input clause_vec_t exp, input clause_vec_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input wb_dat_t exp, input wb_dat_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    // one classic cycle, held through the ack edge where the slave writes
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                             output wb_dat_t rdat);
        int waited;
        waited     = 0;
        rdat       = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
        if (!wb_rsp.ack) begin
            abort_run($sformatf("no ack from the slave for address %0d", adr));
        end else begin
            rdat = wb_rsp.dat;
            @(posedge clk);
            #DRIVE_DLY;
            wb_req = '0;
        end
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
        wb_dat_t ignored;
        bus_cycle(1'b1, adr, dat, ignored);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    // poll the status word until done shows up
    task automatic wait_done();
        wb_dat_t st;
        int      polls;
        st    = '0;
        polls = 0;
        while (!st[0] && polls < DONE_TIMEOUT) begin
            wb_read(REG_STATUS, st);
            polls++;
        end
        if (!st[0]) begin
            abort_run("done flag never rose after a start");
        end
    endtask

    // expected pick worked out from the selection rules
    function automatic pick_result_t ref_pick(input case_t c);
        pick_result_t res;
        break_val_t   cnt [NUM_ROWS];
        clause_vec_t  hit;
        logic         found_zero;
        int           best;
        found_zero = 1'b0;
        best       = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            hit    = c.broken[r] & c.mask[r];
            cnt[r] = '0;
            for (int b = 0; b < NUM_CLAUSES; b++) begin
                cnt[r] = cnt[r] + break_val_t'(hit[b]);
            end
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!found_zero && cnt[r] == '0) begin
                found_zero = 1'b1;
                best       = r;
            end
        end
        if (!found_zero && c.noise_en) begin
            // host row past the last one wraps around
            best = int'(c.rand_row);
            if (best >= NUM_ROWS) begin
                best = best - NUM_ROWS;
            end
        end else if (!found_zero) begin
            for (int r = 1; r < NUM_ROWS; r++) begin
                if (cnt[r] < cnt[best]) begin
                    best = r;
                end
            end
        end
        res.row           = row_idx_t'(best);
        res.break_value   = cnt[best];
        res.zero_break    = found_zero;
        res.clause_broken = c.broken[best] & c.mask[best];
        return res;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic case_t make_case(input clause_vec_t b0, b1, b2, m0, m1, m2,
                                        input logic noise, input row_idx_t rr,
                                        input row_idx_t row, input break_val_t brk,
                                        input logic zero, input clause_vec_t vec);
        case_t c;
        c.broken                 = {b2, b1, b0};
        c.mask                   = {m2, m1, m0};
        c.noise_en               = noise;
        c.rand_row               = rr;
        c.expected.row           = row;
        c.expected.break_value   = brk;
        c.expected.zero_break    = zero;
        c.expected.clause_broken = vec;
        return c;
    endfunction

    // operands: broken 0..2, masks 0..2, noise, rand row; then row, count, zero, vector
    task automatic load_cases();
        // nothing broken anywhere, row 0 is a freebie
        cases[0] = make_case(20'h0, 20'h0, 20'h0, 20'h0, 20'h0, 20'h0,
                             1'b0, 2'd0, 2'd0, 5'd0, 1'b1, 20'h0);
        // every clause broken and present
        cases[1] = make_case(20'hFFFFF, 20'hFFFFF, 20'hFFFFF, 20'hFFFFF, 20'hFFFFF, 20'hFFFFF,
                             1'b0, 2'd0, 2'd0, 5'd20, 1'b0, 20'hFFFFF);
        // zero mask on row 0 beats noise
        cases[2] = make_case(20'hFFFFF, 20'hFFFFF, 20'hAAAAA, 20'h00000, 20'hFFFFF, 20'hFFFFF,
                             1'b1, 2'd2, 2'd0, 5'd0, 1'b1, 20'h0);
        // mask hides every broken bit of row 1
        cases[3] = make_case(20'h0F0F0, 20'hAAAAA, 20'h00000, 20'hFFFFF, 20'h55555, 20'hFFFFF,
                             1'b1, 2'd0, 2'd1, 5'd0, 1'b1, 20'h0);
        // alternating patterns, greedy minimum in row 2
        cases[4] = make_case(20'hAAAAA, 20'h55555, 20'hFFFFF, 20'hFFFFF, 20'hFFFFF, 20'h0000F,
                             1'b0, 2'd0, 2'd2, 5'd4, 1'b0, 20'h0000F);
        // rows 1 and 2 tie, lower index wins
        cases[5] = make_case(20'hFFFFF, 20'h000F0, 20'hF0000, 20'h000FF, 20'hFFFFF, 20'hFFFFF,
                             1'b0, 2'd2, 2'd1, 5'd4, 1'b0, 20'h000F0);
        // noise takes the host row
        cases[6] = make_case(20'hFFFFF, 20'h000F0, 20'hF0000, 20'h000FF, 20'hFFFFF, 20'hFFFFF,
                             1'b1, 2'd2, 2'd2, 5'd4, 1'b0, 20'hF0000);
        // host row 3 wraps to row 0
        cases[7] = make_case(20'hFFFFF, 20'h000F0, 20'hF0000, 20'h000FF, 20'hFFFFF, 20'hFFFFF,
                             1'b1, 2'd3, 2'd0, 5'd8, 1'b0, 20'h000FF);
        cases[8] = make_case(20'h00001, 20'h00003, 20'hFFFFF, 20'h00001, 20'h00003, 20'h00000,
                             1'b1, 2'd1, 2'd2, 5'd0, 1'b1, 20'h0);
        cases[9] = make_case(20'hAAAAA, 20'h12345, 20'hFFFFF, 20'h0FFFF, 20'hFFFFF, 20'hFFFFF,
                             1'b1, 2'd1, 2'd1, 5'd7, 1'b0, 20'h12345);
    endtask

    task automatic make_random_case(output case_t c);
        c = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            rng_state   = xorshift32(rng_state);
            c.broken[r] = rng_state[NUM_CLAUSES-1:0];
            rng_state   = xorshift32(rng_state);
            c.mask[r]   = rng_state[NUM_CLAUSES-1:0];
            // empty mask now and then, so freebies show up too
            if (rng_state[31:29] == 3'd0) begin
                c.mask[r] = '0;
            end
        end
        rng_state  = xorshift32(rng_state);
        c.noise_en = rng_state[0];
        c.rand_row = rng_state[ROW_BITS:1];
        c.expected = ref_pick(c);
    endtask

    // load operands, start, then read back and compare the pick
    task automatic run_pick(input case_t c, input string tag);
        wb_dat_t st;
        wb_dat_t res_w;
        wb_dat_t vec_w;
        for (int r = 0; r < NUM_ROWS; r++) begin
            wb_write(wb_adr_t'(int'(REG_BROKEN0) + r), wb_dat_t'(c.broken[r]));
            wb_write(wb_adr_t'(int'(REG_MASK0) + r), wb_dat_t'(c.mask[r]));
        end
        wb_write(REG_CTRL, wb_dat_t'({c.rand_row, c.noise_en}));
        wb_write(REG_START, wb_dat_t'(1));
        // first status read lands in the start cycle
        wb_read(REG_STATUS, st);
        check_flag({tag, " done after start"}, 1'b0, st[0]);
        wait_done();
        wb_read(REG_RESULT, res_w);
        wb_read(REG_RESULT_VEC, vec_w);
        check_row({tag, " result.row"}, c.expected.row, res_w[ROW_BITS-1:0]);
        check_break({tag, " result.break_value"}, c.expected.break_value,
                    res_w[ROW_BITS +: NUM_CLAUSES_BITS]);
        check_flag({tag, " result.zero_break"}, c.expected.zero_break,
                   res_w[ROW_BITS+NUM_CLAUSES_BITS]);
        check_vec({tag, " result.clause_broken"}, c.expected.clause_broken,
                  vec_w[NUM_CLAUSES-1:0]);
        check_word({tag, " result upper bits"}, '0, res_w >> (ROW_BITS + NUM_CLAUSES_BITS + 1));
    endtask

    initial begin
        wb_dat_t w;
        wb_dat_t saved;
        case_t   rc;
        rst_n     = 1'b0;
        wb_req    = '0;
        rng_state = 32'd60;
        load_cases();
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // whole map reads zero out of reset
        for (int a = 0; a < (1 << WB_ADDR_BITS); a++) begin
            wb_read(wb_adr_t'(a), w);
            check_word($sformatf("reg %0d after reset", a), '0, w);
        end

        // operands keep the clause bits only, control its three bits
        wb_write(REG_BROKEN1, 32'hFFFF_FFFF);
        wb_read(REG_BROKEN1, w);
        check_word("broken1 readback", 32'h000F_FFFF, w);
        wb_write(REG_MASK2, 32'h0001_2345);
        wb_read(REG_MASK2, w);
        check_word("mask2 readback", 32'h0001_2345, w);
        wb_write(REG_CTRL, 32'hFFFF_FFFF);
        wb_read(REG_CTRL, w);
        check_word("ctrl readback", 32'h0000_0007, w);

        // holes at 3, 7, 10, 11, 15 and read-only status and result
        for (int a = 0; a < (1 << WB_ADDR_BITS); a++) begin
            if (a == 3 || a == 7 || a >= 10) begin
                wb_write(wb_adr_t'(a), 32'hFFFF_FFFF);
                wb_read(wb_adr_t'(a), w);
                check_word($sformatf("reg %0d after write", a), '0, w);
            end
        end

        foreach (cases[i]) begin
            run_pick(cases[i], $sformatf("case %0d", i));
        end

        // result stays captured while operands change
        wb_read(REG_RESULT, saved);
        wb_write(REG_BROKEN0, 32'h000F_FFFF);
        wb_write(REG_MASK0, 32'h000F_FFFF);
        wb_write(REG_CTRL, 32'h0000_0005);
        wb_read(REG_RESULT, w);
        check_word("result after operand rewrite", saved, w);
        wb_read(REG_STATUS, w);
        check_word("status after operand rewrite", 32'h0000_0001, w);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            make_random_case(rc);
            run_pick(rc, $sformatf("random %0d", i));
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule
